// File: Makefile
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing -Wno-fatal
TOP        ?= tb_ao_peripheral_subsystem
RTL_TOP    ?= ao_peripheral_subsystem
FLIST      ?= flist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FLIST))
	$(VERILATOR) $(FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then \
	  echo "Simulation FAILED"; exit 1; \
	elif ! grep -q "Finished with no errors" $(LOG); then \
	  echo "Simulation ended without a result"; exit 1; \
	else \
	  echo "Simulation PASSED"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: flist.f
rtl/ao_periph_pkg.sv
rtl/ao_apb_port.sv
rtl/ao_bus_arbiter.sv
rtl/ao_reg_demux.sv
rtl/ao_soc_ctrl.sv
rtl/ao_fast_intr_ctrl.sv
rtl/ao_gpio.sv
rtl/ao_peripheral_subsystem.sv
testbench/tb_clk_gen.sv
testbench/tb_ao_peripheral_subsystem.sv

// File: rtl/ao_apb_port.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB3 slave endpoint for one bus master. Holds the request towards the
// arbiter and answers with a one-cycle pready after the grant.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ao_apb_port (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  // APB slave side
  input  logic                 psel_i,
  input  logic                 penable_i,
  input  logic                 pwrite_i,
  input  ao_periph_pkg::addr_t paddr_i,
  input  ao_periph_pkg::data_t pwdata_i,
  output logic                 pready_o,
  output ao_periph_pkg::data_t prdata_o,
  output logic                 pslverr_o,
  // Request towards the arbiter
  output logic                 req_o,
  output logic                 req_write_o,
  output ao_periph_pkg::addr_t req_addr_o,
  output ao_periph_pkg::data_t req_wdata_o,
  input  logic                 gnt_i,
  input  ao_periph_pkg::data_t rsp_rdata_i,
  input  logic                 rsp_err_i
);
  import ao_periph_pkg::*;

  logic  access;
  logic  served_q;
  logic  pready_q;
  logic  err_q;
  data_t rdata_q;

  assign access = psel_i & penable_i;

  // Pending from the first access cycle until granted
  assign req_o       = access & ~served_q;
  assign req_write_o = pwrite_i;
  assign req_addr_o  = paddr_i;
  assign req_wdata_o = pwdata_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      served_q <= 1'b0;
      pready_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      pready_q <= gnt_i;
      err_q    <= gnt_i & rsp_err_i;
      // Stays served until the master leaves the access phase
      if (gnt_i) begin
        served_q <= 1'b1;
      end else if (!access) begin
        served_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_i) begin
      rdata_q <= rsp_rdata_i;
    end
  end

  assign pready_o  = pready_q;
  assign prdata_o  = rdata_q;
  assign pslverr_o = err_q;

endmodule

// File: rtl/ao_bus_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Round-robin arbiter between the master ports. Grants one request per
// cycle and drives it onto the single-cycle register bus.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ao_bus_arbiter #(
  parameter int unsigned NUM_MASTERS = 2
) (
  input  logic                                    clk_i,
  input  logic                                    arst_n_i,
  // Per-master requests
  input  logic                  [NUM_MASTERS-1:0] req_i,
  input  logic                  [NUM_MASTERS-1:0] req_write_i,
  input  ao_periph_pkg::addr_t  [NUM_MASTERS-1:0] req_addr_i,
  input  ao_periph_pkg::data_t  [NUM_MASTERS-1:0] req_wdata_i,
  output logic                  [NUM_MASTERS-1:0] gnt_o,
  // Register bus
  output logic                                    bus_valid_o,
  output logic                                    bus_write_o,
  output ao_periph_pkg::addr_t                    bus_addr_o,
  output ao_periph_pkg::data_t                    bus_wdata_o,
  input  ao_periph_pkg::data_t                    bus_rdata_i,
  input  logic                                    bus_err_i,
  // Shared response, taken only by the granted port
  output ao_periph_pkg::data_t                    rsp_rdata_o,
  output logic                                    rsp_err_o
);

  localparam int unsigned IDX_W = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1;

  logic [IDX_W-1:0] ptr_q;
  logic [IDX_W-1:0] sel;
  logic             found;

  // First requester at or after the pointer
  always_comb begin
    int unsigned idx;
    found = 1'b0;
    sel   = '0;
    for (int unsigned i = 0; i < NUM_MASTERS; i++) begin
      idx = (int'(ptr_q) + i) % NUM_MASTERS;
      if (!found && req_i[idx]) begin
        found = 1'b1;
        sel   = idx[IDX_W-1:0];
      end
    end
  end

  always_comb begin
    for (int unsigned i = 0; i < NUM_MASTERS; i++) begin
      gnt_o[i] = found && (int'(sel) == i);
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q <= '0;
    end else if (found) begin
      ptr_q <= (int'(sel) == NUM_MASTERS - 1) ? '0 : sel + 1'b1;
    end
  end

  assign bus_valid_o = found;
  assign bus_write_o = req_write_i[sel];
  assign bus_addr_o  = req_addr_i[sel];
  assign bus_wdata_o = req_wdata_i[sel];

  assign rsp_rdata_o = bus_rdata_i;
  assign rsp_err_o   = bus_err_i;

endmodule

// File: rtl/ao_fast_intr_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fast-interrupt controller with sticky pending bits and an enable mask.
// Software clears a pending bit by writing 1 to it.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ao_fast_intr_ctrl #(
  parameter int unsigned FAST_INTR_W = 15
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   sel_i,
  input  logic                   write_i,
  input  ao_periph_pkg::offset_t offset_i,
  input  ao_periph_pkg::data_t   wdata_i,
  output ao_periph_pkg::data_t   rdata_o,
  input  logic [FAST_INTR_W-1:0] fast_intr_i,
  output logic [FAST_INTR_W-1:0] fast_intr_o
);
  import ao_periph_pkg::*;

  logic                   we;
  logic [FAST_INTR_W-1:0] clr;
  logic [FAST_INTR_W-1:0] pending_q;
  logic [FAST_INTR_W-1:0] enable_q;

  assign we  = sel_i & write_i;
  assign clr = (we && offset_i == INTR_PENDING_OFS) ? wdata_i[FAST_INTR_W-1:0] : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q <= '0;
      enable_q  <= '0;
    end else begin
      // A new event beats a clear in the same cycle
      pending_q <= (pending_q & ~clr) | fast_intr_i;
      if (we && offset_i == INTR_ENABLE_OFS) begin
        enable_q <= wdata_i[FAST_INTR_W-1:0];
      end
    end
  end

  always_comb begin
    case (offset_i)
      INTR_PENDING_OFS: rdata_o = data_t'(pending_q);
      INTR_ENABLE_OFS:  rdata_o = data_t'(enable_q);
      default:          rdata_o = '0;
    endcase
  end

  assign fast_intr_o = pending_q & enable_q;

endmodule

// File: rtl/ao_gpio.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// GPIO bank with output, output enable, synchronised input and level
// interrupts masked by INTR_EN.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ao_gpio #(
  parameter int unsigned GPIO_W = 8
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   sel_i,
  input  logic                   write_i,
  input  ao_periph_pkg::offset_t offset_i,
  input  ao_periph_pkg::data_t   wdata_i,
  output ao_periph_pkg::data_t   rdata_o,
  input  logic [GPIO_W-1:0]      gpio_i,
  output logic [GPIO_W-1:0]      gpio_o,
  output logic [GPIO_W-1:0]      gpio_en_o,
  output logic [GPIO_W-1:0]      intr_gpio_o
);
  import ao_periph_pkg::*;

  logic              we;
  logic [GPIO_W-1:0] meta_q;
  logic [GPIO_W-1:0] sync_q;
  logic [GPIO_W-1:0] out_q;
  logic [GPIO_W-1:0] out_en_q;
  logic [GPIO_W-1:0] intr_en_q;

  assign we = sel_i & write_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      meta_q    <= '0;
      sync_q    <= '0;
      out_q     <= '0;
      out_en_q  <= '0;
      intr_en_q <= '0;
    end else begin
      // Two-flop input synchroniser
      meta_q <= gpio_i;
      sync_q <= meta_q;
      if (we) begin
        case (offset_i)
          GPIO_OUT_OFS:     out_q     <= wdata_i[GPIO_W-1:0];
          GPIO_OUT_EN_OFS:  out_en_q  <= wdata_i[GPIO_W-1:0];
          GPIO_INTR_EN_OFS: intr_en_q <= wdata_i[GPIO_W-1:0];
          default:          ;
        endcase
      end
    end
  end

  always_comb begin
    case (offset_i)
      GPIO_IN_OFS:      rdata_o = data_t'(sync_q);
      GPIO_OUT_OFS:     rdata_o = data_t'(out_q);
      GPIO_OUT_EN_OFS:  rdata_o = data_t'(out_en_q);
      GPIO_INTR_EN_OFS: rdata_o = data_t'(intr_en_q);
      default:          rdata_o = '0;
    endcase
  end

  assign gpio_o      = out_q;
  assign gpio_en_o   = out_en_q;
  assign intr_gpio_o = sync_q & intr_en_q;

endmodule

// File: rtl/ao_periph_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared bus widths, address map and register offsets of the always-on
// peripheral block. Imported by every RTL module and by the testbench.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package ao_periph_pkg;

  // Bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // Peripheral indices on the register bus
  localparam int unsigned NUM_PERIPH = 3;

  typedef logic [1:0] periph_sel_t;

  localparam periph_sel_t SOC_CTRL_IDX  = 2'd0;
  localparam periph_sel_t FAST_INTR_IDX = 2'd1;
  localparam periph_sel_t GPIO_IDX      = 2'd2;

  // Address map, one 4 KiB region per peripheral
  localparam addr_t SOC_CTRL_BASE  = 32'h0000_0000;
  localparam addr_t FAST_INTR_BASE = 32'h0000_1000;
  localparam addr_t GPIO_BASE      = 32'h0000_2000;

  localparam int unsigned REGION_SIZE = 4096;

  typedef logic [11:0] offset_t;

  // System control
  localparam offset_t EXIT_VALID_OFS   = 12'h000;
  localparam offset_t EXIT_VALUE_OFS   = 12'h004;
  localparam offset_t BOOT_STRAP_OFS   = 12'h008;

  // Fast-interrupt controller
  localparam offset_t INTR_PENDING_OFS = 12'h000;
  localparam offset_t INTR_ENABLE_OFS  = 12'h004;

  // GPIO bank
  localparam offset_t GPIO_IN_OFS      = 12'h000;
  localparam offset_t GPIO_OUT_OFS     = 12'h004;
  localparam offset_t GPIO_OUT_EN_OFS  = 12'h008;
  localparam offset_t GPIO_INTR_EN_OFS = 12'h00C;

endpackage

// File: rtl/ao_peripheral_subsystem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Always-on peripheral block: one APB port per master, a round-robin
// arbiter, the register decoder and the three register peripherals.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ao_peripheral_subsystem #(
  parameter int unsigned NUM_MASTERS = 2,
  parameter int unsigned GPIO_W      = 8,
  parameter int unsigned FAST_INTR_W = 15
) (
  input  logic                                   clk_i,
  input  logic                                   arst_n_i,
  // APB ports, one per master
  input  logic                 [NUM_MASTERS-1:0] psel_i,
  input  logic                 [NUM_MASTERS-1:0] penable_i,
  input  logic                 [NUM_MASTERS-1:0] pwrite_i,
  input  ao_periph_pkg::addr_t [NUM_MASTERS-1:0] paddr_i,
  input  ao_periph_pkg::data_t [NUM_MASTERS-1:0] pwdata_i,
  output logic                 [NUM_MASTERS-1:0] pready_o,
  output ao_periph_pkg::data_t [NUM_MASTERS-1:0] prdata_o,
  output logic                 [NUM_MASTERS-1:0] pslverr_o,
  // System control
  input  logic                                   boot_select_i,
  input  logic                                   execute_from_flash_i,
  output logic                                   exit_valid_o,
  output ao_periph_pkg::data_t                   exit_value_o,
  // Fast interrupts
  input  logic                 [FAST_INTR_W-1:0] fast_intr_i,
  output logic                 [FAST_INTR_W-1:0] fast_intr_o,
  // GPIO
  input  logic                 [GPIO_W-1:0]      gpio_i,
  output logic                 [GPIO_W-1:0]      gpio_o,
  output logic                 [GPIO_W-1:0]      gpio_en_o,
  output logic                 [GPIO_W-1:0]      intr_gpio_o
);
  import ao_periph_pkg::*;

  logic  [NUM_MASTERS-1:0] req;
  logic  [NUM_MASTERS-1:0] req_write;
  addr_t [NUM_MASTERS-1:0] req_addr;
  data_t [NUM_MASTERS-1:0] req_wdata;
  logic  [NUM_MASTERS-1:0] gnt;
  data_t                   rsp_rdata;
  logic                    rsp_err;

  logic  bus_valid;
  logic  bus_write;
  addr_t bus_addr;
  data_t bus_wdata;
  data_t bus_rdata;
  logic  bus_err;

  logic  [NUM_PERIPH-1:0] periph_sel;
  logic                   periph_write;
  offset_t                periph_offset;
  data_t                  periph_wdata;
  data_t [NUM_PERIPH-1:0] periph_rdata;

  for (genvar m = 0; m < NUM_MASTERS; m++) begin : gen_apb_port
    ao_apb_port u_apb_port (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .psel_i      (psel_i[m]),
      .penable_i   (penable_i[m]),
      .pwrite_i    (pwrite_i[m]),
      .paddr_i     (paddr_i[m]),
      .pwdata_i    (pwdata_i[m]),
      .pready_o    (pready_o[m]),
      .prdata_o    (prdata_o[m]),
      .pslverr_o   (pslverr_o[m]),
      .req_o       (req[m]),
      .req_write_o (req_write[m]),
      .req_addr_o  (req_addr[m]),
      .req_wdata_o (req_wdata[m]),
      .gnt_i       (gnt[m]),
      .rsp_rdata_i (rsp_rdata),
      .rsp_err_i   (rsp_err)
    );
  end

  ao_bus_arbiter #(
    .NUM_MASTERS (NUM_MASTERS)
  ) u_bus_arbiter (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_i       (req),
    .req_write_i (req_write),
    .req_addr_i  (req_addr),
    .req_wdata_i (req_wdata),
    .gnt_o       (gnt),
    .bus_valid_o (bus_valid),
    .bus_write_o (bus_write),
    .bus_addr_o  (bus_addr),
    .bus_wdata_o (bus_wdata),
    .bus_rdata_i (bus_rdata),
    .bus_err_i   (bus_err),
    .rsp_rdata_o (rsp_rdata),
    .rsp_err_o   (rsp_err)
  );

  ao_reg_demux u_reg_demux (
    .bus_valid_i (bus_valid),
    .bus_write_i (bus_write),
    .bus_addr_i  (bus_addr),
    .bus_wdata_i (bus_wdata),
    .bus_rdata_o (bus_rdata),
    .bus_err_o   (bus_err),
    .sel_o       (periph_sel),
    .write_o     (periph_write),
    .offset_o    (periph_offset),
    .wdata_o     (periph_wdata),
    .rdata_i     (periph_rdata)
  );

  ao_soc_ctrl u_soc_ctrl (
    .clk_i                (clk_i),
    .arst_n_i             (arst_n_i),
    .sel_i                (periph_sel[SOC_CTRL_IDX]),
    .write_i              (periph_write),
    .offset_i             (periph_offset),
    .wdata_i              (periph_wdata),
    .rdata_o              (periph_rdata[SOC_CTRL_IDX]),
    .boot_select_i        (boot_select_i),
    .execute_from_flash_i (execute_from_flash_i),
    .exit_valid_o         (exit_valid_o),
    .exit_value_o         (exit_value_o)
  );

  ao_fast_intr_ctrl #(
    .FAST_INTR_W (FAST_INTR_W)
  ) u_fast_intr_ctrl (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .sel_i       (periph_sel[FAST_INTR_IDX]),
    .write_i     (periph_write),
    .offset_i    (periph_offset),
    .wdata_i     (periph_wdata),
    .rdata_o     (periph_rdata[FAST_INTR_IDX]),
    .fast_intr_i (fast_intr_i),
    .fast_intr_o (fast_intr_o)
  );

  ao_gpio #(
    .GPIO_W (GPIO_W)
  ) u_gpio (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .sel_i       (periph_sel[GPIO_IDX]),
    .write_i     (periph_write),
    .offset_i    (periph_offset),
    .wdata_i     (periph_wdata),
    .rdata_o     (periph_rdata[GPIO_IDX]),
    .gpio_i      (gpio_i),
    .gpio_o      (gpio_o),
    .gpio_en_o   (gpio_en_o),
    .intr_gpio_o (intr_gpio_o)
  );

endmodule

// File: rtl/ao_reg_demux.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address decoder of the register bus. Selects one peripheral, returns its
// read data and flags accesses outside every region.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ao_reg_demux (
  // Register bus from the arbiter
  input  logic                                                    bus_valid_i,
  input  logic                                                    bus_write_i,
  input  ao_periph_pkg::addr_t                                    bus_addr_i,
  input  ao_periph_pkg::data_t                                    bus_wdata_i,
  output ao_periph_pkg::data_t                                    bus_rdata_o,
  output logic                                                    bus_err_o,
  // Peripheral side
  output logic                 [ao_periph_pkg::NUM_PERIPH-1:0]    sel_o,
  output logic                                                    write_o,
  output ao_periph_pkg::offset_t                                  offset_o,
  output ao_periph_pkg::data_t                                    wdata_o,
  input  ao_periph_pkg::data_t [ao_periph_pkg::NUM_PERIPH-1:0]    rdata_i
);
  import ao_periph_pkg::*;

  logic [NUM_PERIPH-1:0] hit;

  // Unsigned distance from each base wraps for addresses below it
  assign hit[SOC_CTRL_IDX]  = (bus_addr_i - SOC_CTRL_BASE) < REGION_SIZE;
  assign hit[FAST_INTR_IDX] = (bus_addr_i - FAST_INTR_BASE) < REGION_SIZE;
  assign hit[GPIO_IDX]      = (bus_addr_i - GPIO_BASE) < REGION_SIZE;

  assign sel_o     = bus_valid_i ? hit : '0;
  assign bus_err_o = bus_valid_i & ~|hit;
  assign write_o   = bus_write_i;
  assign offset_o  = bus_addr_i[$bits(offset_t)-1:0];
  assign wdata_o   = bus_wdata_i;

  // Unmapped reads return zero
  always_comb begin
    bus_rdata_o = '0;
    for (int p = 0; p < NUM_PERIPH; p++) begin
      if (hit[p]) begin
        bus_rdata_o = rdata_i[p];
      end
    end
  end

endmodule

// File: rtl/ao_soc_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// System control registers: exit flag, exit value and boot strap read-back.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ao_soc_ctrl (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   sel_i,
  input  logic                   write_i,
  input  ao_periph_pkg::offset_t offset_i,
  input  ao_periph_pkg::data_t   wdata_i,
  output ao_periph_pkg::data_t   rdata_o,
  input  logic                   boot_select_i,
  input  logic                   execute_from_flash_i,
  output logic                   exit_valid_o,
  output ao_periph_pkg::data_t   exit_value_o
);
  import ao_periph_pkg::*;

  logic  we;
  logic  exit_valid_q;
  data_t exit_value_q;

  assign we = sel_i & write_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
    end else if (we) begin
      if (offset_i == EXIT_VALID_OFS) begin
        exit_valid_q <= wdata_i[0];
      end
      if (offset_i == EXIT_VALUE_OFS) begin
        exit_value_q <= wdata_i;
      end
    end
  end

  always_comb begin
    case (offset_i)
      EXIT_VALID_OFS: rdata_o = data_t'(exit_valid_q);
      EXIT_VALUE_OFS: rdata_o = exit_value_q;
      // Straps read live, bit 1 is the flash boot request
      BOOT_STRAP_OFS: rdata_o = data_t'({execute_from_flash_i, boot_select_i});
      default:        rdata_o = '0;
    endcase
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule

// File: testbench/tb_ao_peripheral_subsystem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench of the always-on peripheral block. Drives both APB masters,
// keeps shadow registers as reference model and compares every response.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_ao_peripheral_subsystem;
  import ao_periph_pkg::*;

  localparam int unsigned NUM_MASTERS = 2;
  localparam int unsigned GPIO_W      = 8;
  localparam int unsigned FAST_INTR_W = 15;
  localparam int unsigned NUM_RAND    = 100;
  // Directed part takes about 300 cycles and a random access at most 5
  localparam int unsigned TIMEOUT_CYCLES = 2000;

  logic                    clk;
  logic                    arst_n;
  logic  [NUM_MASTERS-1:0] psel;
  logic  [NUM_MASTERS-1:0] penable;
  logic  [NUM_MASTERS-1:0] pwrite;
  addr_t [NUM_MASTERS-1:0] paddr;
  data_t [NUM_MASTERS-1:0] pwdata;
  logic  [NUM_MASTERS-1:0] pready;
  data_t [NUM_MASTERS-1:0] prdata;
  logic  [NUM_MASTERS-1:0] pslverr;
  logic                    boot_select;
  logic                    execute_from_flash;
  logic                    exit_valid;
  data_t                   exit_value;
  logic [FAST_INTR_W-1:0]  fast_intr_in;
  logic [FAST_INTR_W-1:0]  fast_intr_out;
  logic [GPIO_W-1:0]       gpio_in;
  logic [GPIO_W-1:0]       gpio_out;
  logic [GPIO_W-1:0]       gpio_en;
  logic [GPIO_W-1:0]       intr_gpio;

  // Shadow registers
  logic                   sh_exit_valid;
  data_t                  sh_exit_value;
  logic [GPIO_W-1:0]      sh_gpio_in;
  logic [GPIO_W-1:0]      sh_gpio_out;
  logic [GPIO_W-1:0]      sh_gpio_oe;
  logic [GPIO_W-1:0]      sh_gpio_ie;
  logic [FAST_INTR_W-1:0] sh_pending;
  logic [FAST_INTR_W-1:0] sh_intr_en;

  // Expected response of the access in flight for each master
  data_t exp_rdata   [NUM_MASTERS];
  logic  exp_err     [NUM_MASTERS];
  logic  exp_is_read [NUM_MASTERS];

  int unsigned errors;
  int unsigned checks;
  int unsigned cycle_cnt;
  integer      seed;
  data_t       rnd;

  tb_clk_gen #(.PERIOD_NS (40)) u_clk_gen (.clk_o (clk));

  ao_peripheral_subsystem #(
    .NUM_MASTERS (NUM_MASTERS),
    .GPIO_W      (GPIO_W),
    .FAST_INTR_W (FAST_INTR_W)
  ) uut (
    .clk_i                (clk),
    .arst_n_i             (arst_n),
    .psel_i               (psel),
    .penable_i            (penable),
    .pwrite_i             (pwrite),
    .paddr_i              (paddr),
    .pwdata_i             (pwdata),
    .pready_o             (pready),
    .prdata_o             (prdata),
    .pslverr_o            (pslverr),
    .boot_select_i        (boot_select),
    .execute_from_flash_i (execute_from_flash),
    .exit_valid_o         (exit_valid),
    .exit_value_o         (exit_value),
    .fast_intr_i          (fast_intr_in),
    .fast_intr_o          (fast_intr_out),
    .gpio_i               (gpio_in),
    .gpio_o               (gpio_out),
    .gpio_en_o            (gpio_en),
    .intr_gpio_o          (intr_gpio)
  );

  function automatic logic addr_unmapped(addr_t a);
    return a >= (GPIO_BASE + REGION_SIZE);
  endfunction

  // Expected read data from the register rules
  function automatic data_t model_read(addr_t a);
    offset_t ofs;
    data_t   r;
    ofs = a[11:0];
    r   = '0;
    case (a[31:12])
      SOC_CTRL_BASE[31:12]: begin
        if (ofs == EXIT_VALID_OFS) r = data_t'(sh_exit_valid);
        if (ofs == EXIT_VALUE_OFS) r = sh_exit_value;
        if (ofs == BOOT_STRAP_OFS) r = data_t'({execute_from_flash, boot_select});
      end
      FAST_INTR_BASE[31:12]: begin
        if (ofs == INTR_PENDING_OFS) r = data_t'(sh_pending);
        if (ofs == INTR_ENABLE_OFS)  r = data_t'(sh_intr_en);
      end
      GPIO_BASE[31:12]: begin
        if (ofs == GPIO_IN_OFS)      r = data_t'(sh_gpio_in);
        if (ofs == GPIO_OUT_OFS)     r = data_t'(sh_gpio_out);
        if (ofs == GPIO_OUT_EN_OFS)  r = data_t'(sh_gpio_oe);
        if (ofs == GPIO_INTR_EN_OFS) r = data_t'(sh_gpio_ie);
      end
      default: r = '0;
    endcase
    return r;
  endfunction

  task automatic model_write(input addr_t a, input data_t d);
    offset_t ofs;
    ofs = a[11:0];
    if (a[31:12] == SOC_CTRL_BASE[31:12]) begin
      if (ofs == EXIT_VALID_OFS) sh_exit_valid = d[0];
      if (ofs == EXIT_VALUE_OFS) sh_exit_value = d;
    end else if (a[31:12] == FAST_INTR_BASE[31:12]) begin
      if (ofs == INTR_PENDING_OFS) sh_pending = sh_pending & ~d[FAST_INTR_W-1:0];
      if (ofs == INTR_ENABLE_OFS)  sh_intr_en = d[FAST_INTR_W-1:0];
    end else if (a[31:12] == GPIO_BASE[31:12]) begin
      if (ofs == GPIO_OUT_OFS)     sh_gpio_out = d[GPIO_W-1:0];
      if (ofs == GPIO_OUT_EN_OFS)  sh_gpio_oe  = d[GPIO_W-1:0];
      if (ofs == GPIO_INTR_EN_OFS) sh_gpio_ie  = d[GPIO_W-1:0];
    end
  endtask

  task automatic check_data(input string what, input data_t act, input data_t exp);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, act, exp);
    end
  endtask

  task automatic check_err(input string what, input logic act, input logic exp);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %b, expected %b", $time, what, act, exp);
    end
  endtask

  task automatic check_pins();
    check_err("exit_valid_o", exit_valid, sh_exit_valid);
    check_data("exit_value_o", exit_value, sh_exit_value);
    check_data("gpio_o", data_t'(gpio_out), data_t'(sh_gpio_out));
    check_data("gpio_en_o", data_t'(gpio_en), data_t'(sh_gpio_oe));
    check_data("intr_gpio_o", data_t'(intr_gpio), data_t'(sh_gpio_in & sh_gpio_ie));
    check_data("fast_intr_o", data_t'(fast_intr_out), data_t'(sh_pending & sh_intr_en));
  endtask

  // Called and returns 2 ns after a rising edge
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  task automatic apb_access(input int m, input logic wr, input addr_t a, input data_t d);
    exp_err[m]     = addr_unmapped(a);
    exp_rdata[m]   = exp_err[m] ? '0 : model_read(a);
    exp_is_read[m] = !wr;
    if (wr && !exp_err[m]) model_write(a, d);
    psel[m]    = 1'b1;
    penable[m] = 1'b0;
    pwrite[m]  = wr;
    paddr[m]   = a;
    pwdata[m]  = d;
    @(posedge clk);
    #2 penable[m] = 1'b1;
    do begin
      @(posedge clk);
      #1;
    end while (!pready[m]);
    #1;
    psel[m]    = 1'b0;
    penable[m] = 1'b0;
  endtask

  task automatic read_all_regs();
    addr_t regs [9];
    regs = '{EXIT_VALID_OFS, EXIT_VALUE_OFS, BOOT_STRAP_OFS,
             FAST_INTR_BASE + INTR_PENDING_OFS, FAST_INTR_BASE + INTR_ENABLE_OFS,
             GPIO_BASE + GPIO_IN_OFS, GPIO_BASE + GPIO_OUT_OFS,
             GPIO_BASE + GPIO_OUT_EN_OFS, GPIO_BASE + GPIO_INTR_EN_OFS};
    foreach (regs[i]) apb_access(0, 1'b0, regs[i], '0);
  endtask

  // Each master writes only its own registers and its model stays exact under contention
  task automatic random_traffic(input int m, input int n);
    addr_t own [2][3];
    data_t r;
    addr_t a;
    own = '{'{SOC_CTRL_BASE + EXIT_VALID_OFS, SOC_CTRL_BASE + EXIT_VALUE_OFS,
              GPIO_BASE + GPIO_OUT_OFS},
            '{FAST_INTR_BASE + INTR_ENABLE_OFS, GPIO_BASE + GPIO_OUT_EN_OFS,
              GPIO_BASE + GPIO_INTR_EN_OFS}};
    for (int i = 0; i < n; i++) begin
      r = $random(seed);
      // An idle cycle now and then shifts the masters against each other
      if (r[3]) begin
        wait_cycles(1);
      end
      if (r[1:0] == 2'd3) a = 32'h0000_3000 + (data_t'($random(seed)) & 32'h0fff_fffc);
      else a = own[m][r[1:0]];
      apb_access(m, r[2], a, $random(seed));
    end
  endtask

  // One look per cycle once the outputs have settled
  always @(posedge clk) begin
    #1;
    for (int m = 0; m < NUM_MASTERS; m++) begin
      if (pready[m]) begin
        check_err($sformatf("pslverr_o[%0d]", m), pslverr[m], exp_err[m]);
        if (exp_is_read[m]) begin
          check_data($sformatf("prdata_o[%0d]", m), prdata[m], exp_rdata[m]);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Finished with errors");
      $finish;
    end
  end

  initial begin
    seed = 32'h0530424e;
    errors = 0;
    checks = 0;
    cycle_cnt = 0;
    arst_n = 1'b0;
    psel = '0;
    penable = '0;
    pwrite = '0;
    paddr = '0;
    pwdata = '0;
    boot_select = 1'b0;
    execute_from_flash = 1'b0;
    fast_intr_in = '0;
    gpio_in = '0;
    {sh_exit_valid, sh_exit_value, sh_gpio_in, sh_gpio_out} = '0;
    {sh_gpio_oe, sh_gpio_ie, sh_pending, sh_intr_en} = '0;
    foreach (exp_err[m]) begin
      exp_err[m] = 1'b0;
      exp_rdata[m] = '0;
      exp_is_read[m] = 1'b0;
    end
    repeat (16) @(posedge clk);
    #2 arst_n = 1'b1;
    wait_cycles(1);

    // Reset values
    check_err("pready_o[0]", pready[0], 1'b0);
    check_err("pready_o[1]", pready[1], 1'b0);
    check_err("pslverr_o[0]", pslverr[0], 1'b0);
    check_err("pslverr_o[1]", pslverr[1], 1'b0);
    check_pins();
    read_all_regs();

    // Read/write registers and their pins
    apb_access(0, 1'b1, SOC_CTRL_BASE + EXIT_VALID_OFS, 32'h1);
    apb_access(0, 1'b1, SOC_CTRL_BASE + EXIT_VALUE_OFS, $random(seed));
    apb_access(0, 1'b1, GPIO_BASE + GPIO_OUT_OFS, $random(seed));
    apb_access(0, 1'b1, GPIO_BASE + GPIO_OUT_EN_OFS, $random(seed));
    apb_access(0, 1'b1, FAST_INTR_BASE + INTR_ENABLE_OFS, $random(seed));
    check_pins();
    read_all_regs();

    // Boot straps, GPIO input and level interrupts
    boot_select = 1'b1;
    apb_access(0, 1'b0, SOC_CTRL_BASE + BOOT_STRAP_OFS, '0);
    execute_from_flash = 1'b1;
    apb_access(0, 1'b0, SOC_CTRL_BASE + BOOT_STRAP_OFS, '0);
    boot_select = 1'b0;
    apb_access(0, 1'b0, SOC_CTRL_BASE + BOOT_STRAP_OFS, '0);
    rnd = $random(seed);
    gpio_in = rnd[GPIO_W-1:0];
    wait_cycles(3);
    sh_gpio_in = gpio_in;
    apb_access(0, 1'b1, GPIO_BASE + GPIO_INTR_EN_OFS, $random(seed));
    apb_access(0, 1'b0, GPIO_BASE + GPIO_IN_OFS, '0);
    check_pins();

    // Fast-interrupt pulse and a clear in two steps
    rnd = $random(seed);
    fast_intr_in = rnd[FAST_INTR_W-1:0];
    wait_cycles(1);
    fast_intr_in = '0;
    sh_pending = sh_pending | rnd[FAST_INTR_W-1:0];
    wait_cycles(1);
    check_pins();
    apb_access(0, 1'b0, FAST_INTR_BASE + INTR_PENDING_OFS, '0);
    apb_access(0, 1'b1, FAST_INTR_BASE + INTR_PENDING_OFS, $random(seed));
    apb_access(0, 1'b0, FAST_INTR_BASE + INTR_PENDING_OFS, '0);
    check_pins();
    apb_access(0, 1'b1, FAST_INTR_BASE + INTR_PENDING_OFS, 32'hffff_ffff);
    apb_access(0, 1'b0, FAST_INTR_BASE + INTR_PENDING_OFS, '0);
    check_pins();

    // Unmapped accesses
    apb_access(0, 1'b0, 32'h0000_3000, '0);
    apb_access(0, 1'b1, 32'h8000_0004, $random(seed));
    read_all_regs();
    check_pins();

    // Both masters at once
    fork
      random_traffic(0, NUM_RAND);
      random_traffic(1, NUM_RAND);
    join
    read_all_regs();
    check_pins();
    wait_cycles(2);

    $display("Run complete: %0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: testbench/tb_clk_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Free-running testbench clock, 40 ns period by default
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS = 40
) (
  output logic clk_o
);

  initial clk_o = 1'b0;

  always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule
